/* kws_params.svh */
`ifndef KWS_PARAMS_SVH
`define KWS_PARAMS_SVH

`define KWS_DATA_W      32     // bus width and packed word width
`define KWS_LANE_W      16     // one signed lane of a packed word
`define KWS_LEN_W       8      // frame length field of a start word
`define KWS_CNT_W       3      // fill levels and credit counters
`define KWS_ADDR_W      5      // low address bits seen by the map
`define KWS_IN_DEPTH    4      // core input fifo depth and initial slave credits
`define KWS_RES_DEPTH   4      // result fifo depth and initial core credits
`define KWS_OP_LSB      30     // two-bit opcode field of a control word

// byte offsets of the register map
`define KWS_ADDR_CTRL   5'h00  // control words
`define KWS_ADDR_DATA   5'h04  // packed data
`define KWS_ADDR_WEIGHT 5'h08  // packed weights
`define KWS_ADDR_RESULT 5'h0C  // read pops one result
`define KWS_ADDR_STATUS 5'h10  // result fill level

`endif

/* kws_pkg.sv */
`include "kws_params.svh"

package kws_pkg;

  // what a stream word carries
  typedef enum logic [1:0] {
    kind_ctrl   = 2'd0,
    kind_data   = 2'd1,
    kind_weight = 2'd2
  } kws_kind_e;

  // control word opcodes
  typedef enum logic [1:0] {
    op_nop   = 2'd0,
    op_start = 2'd1,
    op_abort = 2'd2
  } kws_op_e;

  typedef enum logic {
    st_idle = 1'b0,             // waiting for a start
    st_run  = 1'b1              // counting weights of a frame
  } kws_state_e;

  typedef struct packed {
    logic                   valid;   // word sent this cycle
    kws_kind_e              kind;
    logic [`KWS_DATA_W-1:0] data;
  } kws_word_t;

  typedef struct packed {
    logic                   valid;   // result pushed / fifo head present
    logic [`KWS_DATA_W-1:0] acc;
  } kws_result_t;

  typedef struct packed {
    logic                   hsel;
    logic [1:0]             htrans;
    logic                   hwrite;
    logic [`KWS_ADDR_W-1:0] haddr;   // only the low bits are decoded
    logic [`KWS_DATA_W-1:0] hwdata;
  } kws_ahb_req_t;

  typedef struct packed {
    logic                   hready;
    logic [`KWS_DATA_W-1:0] hrdata;
  } kws_ahb_rsp_t;

endpackage

/* kws_ahb_slave.sv */
`timescale 1ns/1ps
`include "kws_params.svh"

module kws_ahb_slave (
  input  logic                  hclk0,
  input  logic                  hrst_b0,
  input  kws_pkg::kws_ahb_req_t ahb_req,
  output kws_pkg::kws_ahb_rsp_t ahb_rsp,
  output kws_pkg::kws_word_t    in_word,
  input  logic                  in_credit,
  input  kws_pkg::kws_result_t  head,
  input  logic [`KWS_CNT_W-1:0] count,
  output logic                  pop
);

  logic                   hready;      // our own hready, also gates address sampling
  logic                   addr_act;    // NONSEQ or SEQ to this slave
  logic                   dp_act;      // accepted transfer now in data phase
  logic                   dp_write;
  logic [`KWS_ADDR_W-1:0] dp_addr;
  logic                   dp_read;
  logic                   dp_stream;   // write that goes to the core
  kws_pkg::kws_kind_e     dp_kind;
  logic                   send;        // word leaves for the core this cycle
  logic [`KWS_CNT_W-1:0]  credit_cnt;  // free slots left in core input fifo
  logic [`KWS_DATA_W-1:0] rdata;

  ////////////////////////////////////////
  // address phase
  ////////////////////////////////////////
  assign addr_act = ahb_req.hsel & ahb_req.htrans[1];  // htrans[1] set for NONSEQ/SEQ

  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      dp_act   <= 1'b0;
      dp_write <= 1'b0;
      dp_addr  <= '0;
    end else if (hready) begin         // hold the data phase through wait states
      dp_act   <= addr_act;
      dp_write <= ahb_req.hwrite;
      dp_addr  <= ahb_req.haddr;
    end
  end

  ////////////////////////////////////////
  // write side, stream words and credits
  ////////////////////////////////////////
  always_comb begin
    dp_stream = dp_act & dp_write;
    dp_kind   = kws_pkg::kind_ctrl;
    case (dp_addr)
      `KWS_ADDR_CTRL:   dp_kind = kws_pkg::kind_ctrl;
      `KWS_ADDR_DATA:   dp_kind = kws_pkg::kind_data;
      `KWS_ADDR_WEIGHT: dp_kind = kws_pkg::kind_weight;
      default:          dp_stream = 1'b0;   // unmapped write is dropped, no wait
    endcase
  end

  assign send   = dp_stream & (credit_cnt != '0);
  assign hready = ~(dp_stream & (credit_cnt == '0));  // stall only when out of credit

  assign in_word.valid = send;
  assign in_word.kind  = dp_kind;
  assign in_word.data  = ahb_req.hwdata;  // hwdata is live in the data phase

  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      credit_cnt <= `KWS_CNT_W'(`KWS_IN_DEPTH);
    end else begin
      case ({send, in_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;  // word spent a slot
        2'b01:   credit_cnt <= credit_cnt + 1'b1;  // core freed a slot
        default: ;                                  // none or both
      endcase
    end
  end

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////
  assign dp_read = dp_act & ~dp_write;

  always_comb begin
    rdata = '0;
    if (dp_read) begin
      case (dp_addr)
        `KWS_ADDR_RESULT: rdata = head.valid ? head.acc : '0;  // empty reads zero
        `KWS_ADDR_STATUS: rdata = {{(`KWS_DATA_W-`KWS_CNT_W){1'b0}}, count};
        default:          rdata = '0;
      endcase
    end
  end

  // reads never stall, so each result read pops at most once
  assign pop = dp_read & (dp_addr == `KWS_ADDR_RESULT) & head.valid;

  assign ahb_rsp.hready = hready;
  assign ahb_rsp.hrdata = rdata;

endmodule

/* kws_mac_core.sv */
`timescale 1ns/1ps
`include "kws_params.svh"

module kws_mac_core (
  input  logic                 hclk0,
  input  logic                 hrst_b0,
  input  kws_pkg::kws_word_t   in_word,
  output logic                 in_credit,
  output kws_pkg::kws_result_t res,
  input  logic                 res_credit
);

  localparam int PTR_W = $clog2(`KWS_IN_DEPTH);

  kws_pkg::kws_word_t            fifo_mem [`KWS_IN_DEPTH];  // stream words, no reset
  logic [PTR_W-1:0]              wr_ptr;
  logic [PTR_W-1:0]              rd_ptr;
  logic [`KWS_CNT_W-1:0]         fifo_cnt;
  kws_pkg::kws_word_t            cur;       // word at the fifo head
  kws_pkg::kws_op_e              op;        // opcode if cur is a control word
  logic [`KWS_LEN_W-1:0]         len;       // frame length if cur is a start
  logic                          take;      // head word consumed this cycle
  logic                          last_wt;   // head is the weight that ends the frame
  logic                          emit;      // result goes out this cycle
  kws_pkg::kws_state_e           state;
  logic [`KWS_LEN_W-1:0]         remain;    // weights still due in this frame
  logic [`KWS_DATA_W-1:0]        dat_q;     // data word waiting for its weight
  logic [`KWS_DATA_W-1:0]        acc;
  logic signed [`KWS_DATA_W-1:0] prod_lo;
  logic signed [`KWS_DATA_W-1:0] prod_hi;
  logic [`KWS_DATA_W-1:0]        acc_sum;   // wraps at 32 bits
  logic [`KWS_CNT_W-1:0]         res_cnt;   // free result fifo slots
  logic                          res_valid;
  logic [`KWS_DATA_W-1:0]        res_acc;

  ////////////////////////////////////////
  // input fifo
  ////////////////////////////////////////
  always_ff @(posedge hclk0) begin
    if (in_word.valid) fifo_mem[wr_ptr] <= in_word;  // slave holds a credit for it
  end

  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (in_word.valid) wr_ptr <= wr_ptr + 1'b1;  // power of two depth wraps
      if (take)          rd_ptr <= rd_ptr + 1'b1;
      case ({in_word.valid, take})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: ;
      endcase
    end
  end

  assign cur = fifo_mem[rd_ptr];
  assign op  = kws_pkg::kws_op_e'(cur.data[`KWS_OP_LSB +: 2]);
  assign len = cur.data[`KWS_LEN_W-1:0];

  assign last_wt = (state == kws_pkg::st_run) && (cur.kind == kws_pkg::kind_weight) &&
                   (remain == `KWS_LEN_W'(1));
  // hold the frame-ending weight until a result slot is free
  assign take      = (fifo_cnt != '0) & ~(last_wt & (res_cnt == '0));
  assign emit      = take & last_wt;
  assign in_credit = take;  // one credit back per removed word

  ////////////////////////////////////////
  // two-lane multiply-accumulate
  ////////////////////////////////////////
  assign prod_lo = $signed(dat_q[`KWS_LANE_W-1:0]) * $signed(cur.data[`KWS_LANE_W-1:0]);
  assign prod_hi = $signed(dat_q[`KWS_DATA_W-1:`KWS_LANE_W]) *
                   $signed(cur.data[`KWS_DATA_W-1:`KWS_LANE_W]);
  assign acc_sum = acc + prod_lo + prod_hi;

  always_ff @(posedge hclk0) begin
    if (take) begin
      if (cur.kind == kws_pkg::kind_ctrl && op == kws_pkg::op_start)
        acc <= '0;                                   // new frame
      if (state == kws_pkg::st_run && cur.kind == kws_pkg::kind_data)
        dat_q <= cur.data;                           // held for the next weight
      if (state == kws_pkg::st_run && cur.kind == kws_pkg::kind_weight)
        acc <= acc_sum;
    end
    if (emit) res_acc <= acc_sum;                    // includes the last pair
  end

  ////////////////////////////////////////
  // frame fsm
  ////////////////////////////////////////
  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      state  <= kws_pkg::st_idle;
      remain <= '0;
    end else if (take) begin
      case (cur.kind)
        kws_pkg::kind_ctrl: begin
          if (op == kws_pkg::op_start) begin
            remain <= len;
            state  <= (len != '0) ? kws_pkg::st_run : kws_pkg::st_idle;  // zero length is a no-op
          end else if (op == kws_pkg::op_abort) begin
            state  <= kws_pkg::st_idle;              // frame dropped, nothing emitted
          end
        end
        kws_pkg::kind_weight: begin
          if (state == kws_pkg::st_run) begin
            remain <= remain - 1'b1;
            if (last_wt) state <= kws_pkg::st_idle;
          end
        end
        default: ;                                   // data only touches dat_q
      endcase
    end
  end

  ////////////////////////////////////////
  // result push and credits
  ////////////////////////////////////////
  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      res_valid <= 1'b0;
      res_cnt   <= `KWS_CNT_W'(`KWS_RES_DEPTH);
    end else begin
      res_valid <= emit;
      case ({emit, res_credit})
        2'b10:   res_cnt <= res_cnt - 1'b1;
        2'b01:   res_cnt <= res_cnt + 1'b1;
        default: ;
      endcase
    end
  end

  assign res.valid = res_valid;
  assign res.acc   = res_acc;

endmodule

/* kws_result_fifo.sv */
`timescale 1ns/1ps
`include "kws_params.svh"

module kws_result_fifo (
  input  logic                  hclk0,
  input  logic                  hrst_b0,
  input  kws_pkg::kws_result_t  res,
  input  logic                  pop,
  output kws_pkg::kws_result_t  head,
  output logic [`KWS_CNT_W-1:0] count,
  output logic                  res_credit
);

  localparam int PTR_W = $clog2(`KWS_RES_DEPTH);

  logic [`KWS_DATA_W-1:0] mem [`KWS_RES_DEPTH];  // accumulators
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [`KWS_CNT_W-1:0]  fill;
  logic                   do_pop;                // pop of a valid head
  logic                   credit_q;

  assign do_pop = pop & (fill != '0);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  always_ff @(posedge hclk0) begin
    if (res.valid) mem[wr_ptr] <= res.acc;  // core only pushes with a credit
  end

  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      credit_q <= 1'b0;
    end else begin
      if (res.valid) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)    rd_ptr <= rd_ptr + 1'b1;
      case ({res.valid, do_pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: ;                           // push and pop together
      endcase
      credit_q <= do_pop;                    // slot freed, hand it back
    end
  end

  assign head.valid = (fill != '0);          // low means empty
  assign head.acc   = mem[rd_ptr];
  assign count      = fill;
  assign res_credit = credit_q;

endmodule

/* kws_top.sv */
`timescale 1ns/1ps
`include "kws_params.svh"

module kws_top (
  input  logic                  hclk0,
  input  logic                  hrst_b0,
  input  kws_pkg::kws_ahb_req_t ahb_req,
  output kws_pkg::kws_ahb_rsp_t ahb_rsp
);

  kws_pkg::kws_word_t    in_word;     // slave to core stream
  logic                  in_credit;   // core to slave credit pulse
  kws_pkg::kws_result_t  res;         // core to result fifo
  logic                  res_credit;  // result fifo to core credit pulse
  kws_pkg::kws_result_t  head;        // oldest result for host reads
  logic [`KWS_CNT_W-1:0] count;       // result fill level for status
  logic                  pop;         // host read of the result address

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////
  kws_ahb_slave u_slave (
    .hclk0     (hclk0),
    .hrst_b0   (hrst_b0),
    .ahb_req   (ahb_req),
    .ahb_rsp   (ahb_rsp),
    .in_word   (in_word),
    .in_credit (in_credit),
    .head      (head),
    .count     (count),
    .pop       (pop)
  );

  // processing
  kws_mac_core u_core (
    .hclk0      (hclk0),
    .hrst_b0    (hrst_b0),
    .in_word    (in_word),
    .in_credit  (in_credit),
    .res        (res),
    .res_credit (res_credit)
  );

  // output side
  kws_result_fifo u_fifo (
    .hclk0      (hclk0),
    .hrst_b0    (hrst_b0),
    .res        (res),
    .pop        (pop),
    .head       (head),
    .count      (count),
    .res_credit (res_credit)
  );

endmodule

/* kws_sva.sv */
`timescale 1ns/1ps
`include "kws_params.svh"

module kws_sva (
  input logic                  hclk0,
  input logic                  hrst_b0,
  input kws_pkg::kws_word_t    in_word,
  input logic                  in_credit
);

  int credits;  // mirror of the slave's input credit counter

  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      credits <= `KWS_IN_DEPTH;
    end else begin
      credits <= credits - int'(in_word.valid) + int'(in_credit);  // send spends, pulse returns
    end
  end

  ////////////////////////////////////////
  // credit rules
  ////////////////////////////////////////
  a_credit_max: assert property (@(posedge hclk0) disable iff (!hrst_b0)
    credits <= `KWS_IN_DEPTH)
    else $error("input credits above core fifo depth");

  a_credit_min: assert property (@(posedge hclk0) disable iff (!hrst_b0)
    credits >= 0)
    else $error("input credits below zero");

  a_send_credit: assert property (@(posedge hclk0) disable iff (!hrst_b0)
    in_word.valid |-> credits != 0)
    else $error("word sent with no input credit");

endmodule

bind kws_top kws_sva u_sva (
  .hclk0     (hclk0),
  .hrst_b0   (hrst_b0),
  .in_word   (in_word),
  .in_credit (in_credit)
);

/* kws_tb.sv */
`timescale 1ns/1ps
`include "kws_params.svh"

module kws_tb;

  localparam int STALL_MAX   = 64;                 // cycles a data phase may wait
  localparam int POLL_MAX    = 32;                 // status reads per poll
  localparam int FRAME_COST  = 1 + 2*8 + 8;        // start, eight pairs, polls and reads
  localparam int XFER_BUDGET = 49*FRAME_COST + 20; // 49 frames over all tests plus spare
  localparam int WD_CYCLES   = XFER_BUDGET*20;

  logic                   hclk0;
  logic                   hrst_b0;
  kws_pkg::kws_ahb_req_t  ahb_req;
  kws_pkg::kws_ahb_rsp_t  ahb_rsp;
  logic [`KWS_DATA_W-1:0] exp_q[$];                // model results, oldest first
  int                     errors;
  int                     checks;
  int                     tests;
  int                     test_err;                // error count when the test began
  int                     last_wait;               // wait states of the last transfer
  bit                     bus_stuck;

  kws_top uut (.hclk0(hclk0), .hrst_b0(hrst_b0), .ahb_req(ahb_req), .ahb_rsp(ahb_rsp));

  always #2 hclk0 = ~hclk0;                        // 4 ns period

  initial begin
    repeat (WD_CYCLES) @(posedge hclk0);
    $display("watchdog: run did not finish within %0d cycles", WD_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // ahb driver, one single transfer
  ////////////////////////////////////////
  task automatic bus_xfer(input bit write, input logic [`KWS_ADDR_W-1:0] addr,
                          input logic [`KWS_DATA_W-1:0] wdata,
                          output logic [`KWS_DATA_W-1:0] rdata);
    int waits;
    waits = 0;
    rdata = '0;
    if (!bus_stuck) begin
      ahb_req.hsel   <= 1'b1;
      ahb_req.htrans <= 2'b10;                     // NONSEQ
      ahb_req.hwrite <= write;
      ahb_req.haddr  <= addr;
      @(posedge hclk0);                            // address phase taken
      ahb_req.hsel   <= 1'b0;
      ahb_req.htrans <= 2'b00;
      ahb_req.hwdata <= write ? wdata : '0;
      @(negedge hclk0);
      while (!ahb_rsp.hready && waits < STALL_MAX) begin
        waits++;                                   // wait state
        @(negedge hclk0);
      end
      if (!ahb_rsp.hready) begin
        $display("bus stuck: hready stayed low %0d cycles at address 0x%02h", STALL_MAX, addr);
        errors++;
        bus_stuck = 1'b1;
      end
      rdata = ahb_rsp.hrdata;                      // stable mid cycle
      @(posedge hclk0);                            // data phase ends
    end
    last_wait = waits;
  endtask

  task automatic bus_write(input logic [`KWS_ADDR_W-1:0] addr, input logic [`KWS_DATA_W-1:0] d);
    logic [`KWS_DATA_W-1:0] unused;
    bus_xfer(1'b1, addr, d, unused);
  endtask

  task automatic bus_read(input logic [`KWS_ADDR_W-1:0] addr, output logic [`KWS_DATA_W-1:0] d);
    bus_xfer(1'b0, addr, '0, d);
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_result(input logic [`KWS_DATA_W-1:0] got,
                              input logic [`KWS_DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error: hrdata got 0x%08h exp 0x%08h", got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input logic [`KWS_CNT_W-1:0] got, input logic [`KWS_CNT_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error: status count got 0x%0h exp 0x%0h", got, exp);
      errors++;
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("error: hready got 0x%0h exp 0x%0h", got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // reference model and frame helpers
  ////////////////////////////////////////
  function automatic logic [`KWS_DATA_W-1:0] pair_mac(input logic [`KWS_DATA_W-1:0] d,
                                                      input logic [`KWS_DATA_W-1:0] w);
    int lo;
    int hi;
    lo = int'($signed(d[`KWS_LANE_W-1:0])) * int'($signed(w[`KWS_LANE_W-1:0]));
    hi = int'($signed(d[`KWS_DATA_W-1:`KWS_LANE_W])) * int'($signed(w[`KWS_DATA_W-1:`KWS_LANE_W]));
    return lo + hi;                                // wraps at 32 bits
  endfunction

  function automatic logic [`KWS_DATA_W-1:0] ctrl_word(input kws_pkg::kws_op_e op, input int len);
    logic [`KWS_DATA_W-1:0] w;
    w = '0;
    w[`KWS_OP_LSB +: 2]  = op;
    w[`KWS_LEN_W-1:0]    = len[`KWS_LEN_W-1:0];
    return w;
  endfunction

  task automatic send_pairs(input int n, inout logic [`KWS_DATA_W-1:0] acc);
    logic [`KWS_DATA_W-1:0] d;
    logic [`KWS_DATA_W-1:0] w;
    for (int i = 0; i < n; i++) begin
      d = $urandom();
      w = $urandom();
      bus_write(`KWS_ADDR_DATA, d);
      bus_write(`KWS_ADDR_WEIGHT, w);
      acc = acc + pair_mac(d, w);
    end
  endtask

  task automatic run_frame(input int len);
    logic [`KWS_DATA_W-1:0] acc;
    acc = '0;
    bus_write(`KWS_ADDR_CTRL, ctrl_word(kws_pkg::op_start, len));
    send_pairs(len, acc);
    exp_q.push_back(acc);                          // expected in push order
  endtask

  task automatic wait_results(input int n, output logic [`KWS_CNT_W-1:0] got);
    logic [`KWS_DATA_W-1:0] rd;
    int polls;
    polls = 0;
    got = '0;
    do begin
      bus_read(`KWS_ADDR_STATUS, rd);
      got = rd[`KWS_CNT_W-1:0];
      polls++;
    end while (got < n && polls < POLL_MAX);
    if (got < n) begin
      $display("status poll gave up: %0d of %0d results appeared", got, n);
      errors++;
    end
  endtask

  task automatic expect_status(input int n);
    logic [`KWS_DATA_W-1:0] rd;
    bus_read(`KWS_ADDR_STATUS, rd);
    check_count(rd[`KWS_CNT_W-1:0], n[`KWS_CNT_W-1:0]);
  endtask

  task automatic drain_one();
    logic [`KWS_DATA_W-1:0] rd;
    logic [`KWS_CNT_W-1:0]  cnt;
    wait_results(1, cnt);
    bus_read(`KWS_ADDR_RESULT, rd);
    check_result(rd, exp_q.pop_front());
  endtask

  task automatic test_end(input string name);
    tests++;
    $display("test %s: %s, %0d errors", name, (errors == test_err) ? "ok" : "bad",
             errors - test_err);
    test_err = errors;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin : main
    logic [`KWS_DATA_W-1:0] rd;
    logic [`KWS_DATA_W-1:0] junk;
    logic [`KWS_CNT_W-1:0]  cnt;
    int                     n;
    hclk0     = 1'b0;
    hrst_b0   = 1'b0;
    ahb_req   = '0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    test_err  = 0;
    bus_stuck = 1'b0;
    last_wait = 0;
    rd        = $urandom(54);                      // seed once
    repeat (3) @(posedge hclk0);
    hrst_b0 <= 1'b1;
    @(posedge hclk0);

    // reset values
    @(negedge hclk0);
    check_ready(ahb_rsp.hready, 1'b1);
    @(posedge hclk0);
    expect_status(0);
    bus_read(`KWS_ADDR_RESULT, rd);
    check_result(rd, '0);
    test_end("reset");

    // one frame
    run_frame($urandom_range(8, 1));
    wait_results(1, cnt);
    check_count(cnt, 1);
    bus_read(`KWS_ADDR_RESULT, rd);
    check_result(rd, exp_q.pop_front());
    expect_status(0);
    test_end("single_frame");

    // result fifo full, fifth frame held at its last weight
    repeat (`KWS_RES_DEPTH) run_frame(1);
    wait_results(`KWS_RES_DEPTH, cnt);
    run_frame($urandom_range(8, 2));
    expect_status(`KWS_RES_DEPTH);                 // no room for the fifth
    repeat (`KWS_IN_DEPTH - 1) bus_write(`KWS_ADDR_DATA, $urandom());  // uses up input credits
    drain_one();
    bus_write(`KWS_ADDR_DATA, $urandom());
    if (last_wait == 0) begin
      $display("no wait state seen on a write while input credits were used up");
      errors++;
    end
    wait_results(`KWS_RES_DEPTH, cnt);
    repeat (`KWS_RES_DEPTH) drain_one();
    expect_status(0);
    test_end("back_pressure");

    // abort midway
    junk = '0;
    bus_write(`KWS_ADDR_CTRL, ctrl_word(kws_pkg::op_start, 6));
    send_pairs(2, junk);
    bus_write(`KWS_ADDR_CTRL, ctrl_word(kws_pkg::op_abort, 0));
    send_pairs(4, junk);                           // would close the old frame without the abort
    run_frame($urandom_range(8, 1));
    wait_results(1, cnt);
    drain_one();
    expect_status(0);
    test_end("abort");

    // idle words and empty reads
    repeat (3) begin
      bus_write(`KWS_ADDR_DATA, $urandom());
      bus_write(`KWS_ADDR_WEIGHT, $urandom());     // ignored in idle
    end
    repeat (2) begin
      bus_read(`KWS_ADDR_RESULT, rd);
      check_result(rd, '0);
    end
    expect_status(0);
    run_frame($urandom_range(8, 1));
    drain_one();
    expect_status(0);
    test_end("idle_words");

    // random frames, gaps and interleaved reads
    for (int f = 0; f < 40; f++) begin
      if (exp_q.size() == `KWS_RES_DEPTH) drain_one();  // keep a result slot free
      run_frame($urandom_range(8, 1));
      repeat ($urandom_range(3, 0)) @(posedge hclk0);
      if ($urandom_range(1, 0) == 1) begin
        n = $urandom_range(exp_q.size(), 0);
        repeat (n) drain_one();
      end
    end
    while (exp_q.size() != 0) drain_one();
    expect_status(0);
    test_end("random_run");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
kws_pkg.sv
kws_ahb_slave.sv
kws_mac_core.sv
kws_result_fifo.sv
kws_top.sv
kws_sva.sv
kws_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := kws_tb
FLIST     := src.f
BIN       := obj_dir/V$(TOP)
LOG       := sim.log
SRCS      := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
